// File: datapathPkg.sv
`default_nettype none

package datapathPkg;

    // Datapath word sizes
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // General register count
    localparam int numRegs = 16;

    // Bus sources: general registers, HI, LO, zHigh, zLow, PC, MDR, cOut
    localparam int numSources = numRegs + 7;
    localparam int srcIdxBits = $clog2(numSources);

    // ALU opcodes, taken from the top five bits of IR
    localparam logic [4:0] opAdd = 5'd3;
    localparam logic [4:0] opSub = 5'd4;
    localparam logic [4:0] opAnd = 5'd5;
    localparam logic [4:0] opOr  = 5'd6;
    localparam logic [4:0] opShr = 5'd7;
    localparam logic [4:0] opShl = 5'd9;
    localparam logic [4:0] opNop = 5'd13;
    localparam logic [4:0] opMul = 5'd15;
    localparam logic [4:0] opNeg = 5'd17;
    localparam logic [4:0] opNot = 5'd18;

    // One instruction word, read either as three registers or as
    // two registers plus a 19-bit constant
    typedef union packed {
        struct packed {
            logic [4:0]  op;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [3:0]  rc;
            logic [14:0] spare;   // Unused in register form
        } regForm;
        struct packed {
            logic [4:0]  op;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [18:0] immValue;  // Signed constant
        } immForm;
    } instr_t;

    // Both views place op in the same bits
    // ra and rb also line up, so either view gives the register fields
    // Only the low 19 bits differ in meaning between the forms

endpackage

`default_nettype wire

// File: busMux.sv
`timescale 1ns/1ns
`default_nettype none

module busMux (
    input  wire logic [datapathPkg::numRegs-1:0] regOut,
    input  wire logic                            hiOut,
    input  wire logic                            loOut,
    input  wire logic                            zHighOut,
    input  wire logic                            zLowOut,
    input  wire logic                            pcOut,
    input  wire logic                            mdrOut,
    input  wire logic                            cOut,
    input  wire datapathPkg::word_t              regWords [datapathPkg::numRegs],
    input  wire datapathPkg::word_t              hiWord,
    input  wire datapathPkg::word_t              loWord,
    input  wire datapathPkg::word_t              zHighWord,
    input  wire datapathPkg::word_t              zLowWord,
    input  wire datapathPkg::word_t              pcWord,
    input  wire datapathPkg::word_t              mdrWord,
    input  wire datapathPkg::word_t              immWord,
    output datapathPkg::word_t                   busValue
);

    logic [datapathPkg::numSources-1:0] selVec;
    logic [datapathPkg::srcIdxBits-1:0] srcIdx;
    logic                               srcValid;
    datapathPkg::word_t                 srcWords [datapathPkg::numSources];

    // Bit order sets the priority, bit 0 wins
    assign selVec = {cOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut, regOut};

    // Gather candidate words in the same order as selVec
    always_comb begin
        for (int i = 0; i < datapathPkg::numRegs; i++) begin
            srcWords[i] = regWords[i];
        end
        srcWords[datapathPkg::numRegs]     = hiWord;
        srcWords[datapathPkg::numRegs + 1] = loWord;
        srcWords[datapathPkg::numRegs + 2] = zHighWord;
        srcWords[datapathPkg::numRegs + 3] = zLowWord;
        srcWords[datapathPkg::numRegs + 4] = pcWord;
        srcWords[datapathPkg::numRegs + 5] = mdrWord;
        srcWords[datapathPkg::numRegs + 6] = immWord;
    end

    // Priority encoder
    // Scans from the top so the lowest set bit is left last
    always_comb begin
        srcIdx   = '0;
        srcValid = 1'b0;
        for (int i = datapathPkg::numSources - 1; i >= 0; i--) begin
            if (selVec[i]) begin
                srcIdx   = datapathPkg::srcIdxBits'(i);
                srcValid = 1'b1;
            end
        end
    end

    assign busValue = srcValid ? srcWords[srcIdx] : '0;  // Idle bus reads zero

endmodule

`default_nettype wire

// File: registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  wire logic                            Clock,
    input  wire logic                            rstN,
    input  wire logic [datapathPkg::numRegs-1:0] regIn,
    input  wire logic                            hiIn,
    input  wire logic                            loIn,
    input  wire datapathPkg::word_t              busValue,
    output datapathPkg::word_t                   regWords [datapathPkg::numRegs],
    output datapathPkg::word_t                   hiWord,
    output datapathPkg::word_t                   loWord
);

    // General registers R0 to R15
    // Any number of strobes may be high, all take the same bus word
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < datapathPkg::numRegs; i++) begin
                regWords[i] <= '0;
            end
        end else begin
            for (int i = 0; i < datapathPkg::numRegs; i++) begin
                if (regIn[i]) begin
                    regWords[i] <= busValue;
                end
            end
        end
    end

    // HI holds the upper multiply half once moved over from Z
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            hiWord <= '0;
        end else if (hiIn) begin
            hiWord <= busValue;
        end
    end

    // LO for the lower half
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            loWord <= '0;
        end else if (loIn) begin
            loWord <= busValue;
        end
    end

endmodule

`default_nettype wire

// File: specialRegisters.sv
`timescale 1ns/1ns
`default_nettype none

module specialRegisters (
    input  wire logic               Clock,
    input  wire logic               rstN,
    input  wire logic               pcIn,
    input  wire logic               irIn,
    input  wire logic               marIn,
    input  wire logic               mdrIn,
    input  wire logic               yIn,
    input  wire logic               read,
    input  wire datapathPkg::word_t memData,
    input  wire datapathPkg::word_t busValue,
    output datapathPkg::word_t      pcWord,
    output datapathPkg::word_t      mdrWord,
    output datapathPkg::word_t      yWord,
    output datapathPkg::word_t      immWord,
    output logic [4:0]              aluOp,
    output datapathPkg::word_t      memAddress
);

    datapathPkg::instr_t irWord;
    datapathPkg::word_t  mdrNext;
    logic [18:0]         immField;

    assign mdrNext = read ? memData : busValue;  // Memory wins during a read

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pcWord     <= '0;
            irWord     <= '0;
            memAddress <= '0;
            mdrWord    <= '0;
            yWord      <= '0;
        end else begin
            if (pcIn) begin
                pcWord <= busValue;
            end
            if (irIn) begin
                irWord <= busValue;
            end
            if (marIn) begin
                memAddress <= busValue;  // MAR drives the address straight out
            end
            if (mdrIn) begin
                mdrWord <= mdrNext;
            end
            if (yIn) begin
                yWord <= busValue;   // Operand A of the ALU
            end
        end
    end

    // Decode IR through both views of the union
    assign aluOp    = irWord.regForm.op;
    assign immField = irWord.immForm.immValue;

    // Sign extend the 19-bit constant for cOut
    assign immWord = {{13{immField[18]}}, immField};

endmodule

`default_nettype wire

// File: aluStage.sv
`timescale 1ns/1ns
`default_nettype none

module aluStage (
    input  wire logic               Clock,
    input  wire logic               rstN,
    input  wire logic               zIn,
    input  wire logic               incPc,
    input  wire logic [4:0]         aluOp,
    input  wire datapathPkg::word_t yWord,
    input  wire datapathPkg::word_t busValue,
    output datapathPkg::word_t      zLowWord,
    output datapathPkg::word_t      zHighWord
);

    datapathPkg::dword_t zReg;
    datapathPkg::dword_t aluResult;
    datapathPkg::word_t  lowResult;
    logic [4:0]          shiftAmount;
    logic signed [63:0]  mulA;
    logic signed [63:0]  mulB;
    logic signed [63:0]  mulProduct;

    assign shiftAmount = busValue[4:0];

    // Signed multiply done at full width
    // Both operands widened first, so the low 64 bits are exact
    assign mulA       = {{32{yWord[31]}}, yWord};
    assign mulB       = {{32{busValue[31]}}, busValue};
    assign mulProduct = mulA * mulB;

    // 32-bit operations, A is Y and B is the bus
    always_comb begin
        case (aluOp)
            datapathPkg::opAdd: lowResult = yWord + busValue;
            datapathPkg::opSub: lowResult = yWord - busValue;
            datapathPkg::opAnd: lowResult = yWord & busValue;
            datapathPkg::opOr:  lowResult = yWord | busValue;
            datapathPkg::opShr: lowResult = yWord >> shiftAmount;  // Logical
            datapathPkg::opShl: lowResult = yWord << shiftAmount;
            datapathPkg::opNeg: lowResult = -busValue;
            datapathPkg::opNot: lowResult = ~busValue;
            datapathPkg::opNop: lowResult = '0;
            default:            lowResult = '0;
        endcase
    end

    // Full result
    // The PC increment takes precedence over whatever IR holds
    always_comb begin
        if (incPc) begin
            aluResult = {32'd0, busValue + 32'd1};
        end else if (aluOp == datapathPkg::opMul) begin
            aluResult = mulProduct;
        end else begin
            aluResult = {32'd0, lowResult};  // High half stays clear
        end
    end

    // Z register
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (zIn) begin
            zReg <= aluResult;
        end
    end

    assign zLowWord  = zReg[31:0];
    assign zHighWord = zReg[63:32];

endmodule

`default_nettype wire

// File: datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
    input  wire logic                            Clock,
    input  wire logic                            rstN,
    input  wire logic [datapathPkg::numRegs-1:0] regOut,
    input  wire logic [datapathPkg::numRegs-1:0] regIn,
    input  wire logic                            hiOut,
    input  wire logic                            hiIn,
    input  wire logic                            loOut,
    input  wire logic                            loIn,
    input  wire logic                            pcOut,
    input  wire logic                            pcIn,
    input  wire logic                            incPc,
    input  wire logic                            irIn,
    input  wire logic                            marIn,
    input  wire logic                            mdrIn,
    input  wire logic                            mdrOut,
    input  wire logic                            read,
    input  wire logic                            yIn,
    input  wire logic                            zIn,
    input  wire logic                            zLowOut,
    input  wire logic                            zHighOut,
    input  wire logic                            cOut,
    input  wire datapathPkg::word_t              memData,
    output datapathPkg::word_t                   busValue,
    output datapathPkg::word_t                   memAddress
);

    datapathPkg::word_t regWords [datapathPkg::numRegs];
    datapathPkg::word_t hiWord;
    datapathPkg::word_t loWord;
    datapathPkg::word_t pcWord;
    datapathPkg::word_t mdrWord;
    datapathPkg::word_t yWord;
    datapathPkg::word_t immWord;
    datapathPkg::word_t zLowWord;
    datapathPkg::word_t zHighWord;
    logic [4:0]         aluOp;

    // Shared bus driver
    busMux u_busMux (
        .regOut    (regOut),
        .hiOut     (hiOut),
        .loOut     (loOut),
        .zHighOut  (zHighOut),
        .zLowOut   (zLowOut),
        .pcOut     (pcOut),
        .mdrOut    (mdrOut),
        .cOut      (cOut),
        .regWords  (regWords),
        .hiWord    (hiWord),
        .loWord    (loWord),
        .zHighWord (zHighWord),
        .zLowWord  (zLowWord),
        .pcWord    (pcWord),
        .mdrWord   (mdrWord),
        .immWord   (immWord),
        .busValue  (busValue)
    );

    registerFile u_registerFile (
        .Clock    (Clock),
        .rstN     (rstN),
        .regIn    (regIn),
        .hiIn     (hiIn),
        .loIn     (loIn),
        .busValue (busValue),
        .regWords (regWords),
        .hiWord   (hiWord),
        .loWord   (loWord)
    );

    specialRegisters u_specialRegisters (
        .Clock      (Clock),
        .rstN       (rstN),
        .pcIn       (pcIn),
        .irIn       (irIn),
        .marIn      (marIn),
        .mdrIn      (mdrIn),
        .yIn        (yIn),
        .read       (read),
        .memData    (memData),
        .busValue   (busValue),
        .pcWord     (pcWord),
        .mdrWord    (mdrWord),
        .yWord      (yWord),
        .immWord    (immWord),
        .aluOp      (aluOp),
        .memAddress (memAddress)
    );

    // Opcode comes from IR, Y is operand A
    aluStage u_aluStage (
        .Clock     (Clock),
        .rstN      (rstN),
        .zIn       (zIn),
        .incPc     (incPc),
        .aluOp     (aluOp),
        .yWord     (yWord),
        .busValue  (busValue),
        .zLowWord  (zLowWord),
        .zHighWord (zHighWord)
    );

endmodule

`default_nettype wire

// File: datapathTb.sv
`timescale 1ns/1ns
`default_nettype none

module datapathTb;

    // One control step with its expected bus and address
    typedef struct packed {
        logic [datapathPkg::numRegs-1:0] regOut;
        logic [datapathPkg::numRegs-1:0] regIn;
        logic hiOut, hiIn, loOut, loIn;
        logic pcOut, pcIn, incPc, irIn, marIn, mdrIn, mdrOut, read;
        logic yIn, zIn, zLowOut, zHighOut, cOut;
        datapathPkg::word_t memData;
        datapathPkg::word_t expBus;
        datapathPkg::word_t expAddr;
        logic checkBusFlag;
        logic checkAddrFlag;
    } step_t;

    logic Clock;
    logic rstN;
    logic [datapathPkg::numRegs-1:0] regOut;
    logic [datapathPkg::numRegs-1:0] regIn;
    logic hiOut, hiIn, loOut, loIn;
    logic pcOut, pcIn, incPc, irIn, marIn, mdrIn, mdrOut, read;
    logic yIn, zIn, zLowOut, zHighOut, cOut;
    datapathPkg::word_t memData;
    datapathPkg::word_t busValue;
    datapathPkg::word_t memAddress;

    step_t rows[$];
    int    cycleCount = 0;
    int    cycleLimit = 0;
    logic [31:0] lfsr = 32'ha63e_6fba;

    // Model state, updated as each row is added
    datapathPkg::word_t  mRegs [datapathPkg::numRegs];
    datapathPkg::word_t  mHi, mLo, mPc, mMar, mMdr, mY;
    datapathPkg::instr_t mIr;
    datapathPkg::dword_t mZ;

    datapath u_dut (
        .Clock(Clock), .rstN(rstN), .regOut(regOut), .regIn(regIn),
        .hiOut(hiOut), .hiIn(hiIn), .loOut(loOut), .loIn(loIn),
        .pcOut(pcOut), .pcIn(pcIn), .incPc(incPc), .irIn(irIn),
        .marIn(marIn), .mdrIn(mdrIn), .mdrOut(mdrOut), .read(read),
        .yIn(yIn), .zIn(zIn), .zLowOut(zLowOut), .zHighOut(zHighOut),
        .cOut(cOut), .memData(memData), .busValue(busValue), .memAddress(memAddress)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // Taps 32, 22, 2, 1
    function automatic datapathPkg::word_t randBits(input int n);
        datapathPkg::word_t r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Lowest priority first, later matches overwrite
    function automatic datapathPkg::word_t modelBus(input step_t s);
        datapathPkg::word_t v;
        v = '0;
        if (s.cOut) v = 32'(signed'(mIr.immForm.immValue));
        if (s.mdrOut) v = mMdr;
        if (s.pcOut) v = mPc;
        if (s.zLowOut) v = mZ[31:0];
        if (s.zHighOut) v = mZ[63:32];
        if (s.loOut) v = mLo;
        if (s.hiOut) v = mHi;
        for (int i = datapathPkg::numRegs - 1; i >= 0; i--) begin
            if (s.regOut[i]) v = mRegs[i];
        end
        return v;
    endfunction

    function automatic datapathPkg::dword_t modelAlu(input logic [4:0] op,
            input datapathPkg::word_t a, input datapathPkg::word_t b, input logic inc);
        datapathPkg::dword_t r;
        r = '0;
        if (inc) begin
            r[31:0] = b + 32'd1;
        end else begin
            case (op)
                datapathPkg::opAdd: r[31:0] = a + b;
                datapathPkg::opSub: r[31:0] = a - b;
                datapathPkg::opAnd: r[31:0] = a & b;
                datapathPkg::opOr:  r[31:0] = a | b;
                datapathPkg::opShr: r[31:0] = a >> b[4:0];
                datapathPkg::opShl: r[31:0] = a << b[4:0];
                datapathPkg::opNeg: r[31:0] = -b;
                datapathPkg::opNot: r[31:0] = ~b;
                datapathPkg::opMul: r = longint'(signed'(a)) * longint'(signed'(b));
                default:            r = '0;
            endcase
        end
        return r;
    endfunction

    // Records expectations, then advances the model past the clock edge
    task automatic addStep(input step_t sIn);
        step_t s;
        datapathPkg::word_t bus;
        datapathPkg::dword_t aluVal;
        s = sIn;
        bus = modelBus(s);
        aluVal = modelAlu(mIr.regForm.op, mY, bus, s.incPc);
        s.expBus = bus;
        s.expAddr = mMar;
        s.checkBusFlag = 1'b1;
        s.checkAddrFlag = 1'b1;
        rows.push_back(s);
        for (int i = 0; i < datapathPkg::numRegs; i++) begin
            if (s.regIn[i]) mRegs[i] = bus;
        end
        if (s.hiIn) mHi = bus;
        if (s.loIn) mLo = bus;
        if (s.pcIn) mPc = bus;
        if (s.irIn) mIr = bus;
        if (s.marIn) mMar = bus;
        if (s.mdrIn) mMdr = s.read ? s.memData : bus;
        if (s.yIn) mY = bus;
        if (s.zIn) mZ = aluVal;
    endtask

    task automatic loadReg(input logic [3:0] r, input datapathPkg::word_t v);
        step_t s;
        s = '0;
        s.read = 1'b1;
        s.mdrIn = 1'b1;
        s.memData = v;
        addStep(s);
        s = '0;
        s.mdrOut = 1'b1;
        s.regIn[r] = 1'b1;
        addStep(s);
    endtask

    task automatic showReg(input logic [3:0] r);
        step_t s;
        s = '0;
        s.regOut[r] = 1'b1;
        addStep(s);
    endtask

    task automatic fetchInstr(input datapathPkg::instr_t w);
        step_t s;
        s = '0;
        {s.pcOut, s.marIn, s.incPc, s.zIn} = 4'b1111;
        addStep(s);
        s = '0;
        {s.zLowOut, s.pcIn, s.read, s.mdrIn} = 4'b1111;  // MAR holds the old PC here
        s.memData = w;
        addStep(s);
        s = '0;
        {s.mdrOut, s.irIn} = 2'b11;
        addStep(s);
        s = '0;
        s.pcOut = 1'b1;
        addStep(s);
    endtask

    // Y from ra, rb on the bus into Z, result to rc
    task automatic runRegOp(input logic [4:0] op);
        datapathPkg::instr_t w;
        step_t s;
        w = '0;
        w.regForm.op = op;
        w.regForm.ra = 4'(randBits(4));
        w.regForm.rb = 4'(randBits(4));
        w.regForm.rc = 4'(randBits(4));
        fetchInstr(w);
        s = '0;
        s.regOut[w.regForm.ra] = 1'b1;
        s.yIn = 1'b1;
        addStep(s);
        s = '0;
        s.regOut[w.regForm.rb] = 1'b1;
        s.zIn = 1'b1;
        addStep(s);
        s = '0;
        s.zLowOut = 1'b1;
        s.regIn[w.regForm.rc] = 1'b1;
        addStep(s);
        showReg(w.regForm.rc);
    endtask

    task automatic runMul();
        step_t s;
        runRegOp(datapathPkg::opMul);
        s = '0;
        {s.zLowOut, s.loIn} = 2'b11;
        addStep(s);
        s = '0;
        {s.zHighOut, s.hiIn} = 2'b11;
        addStep(s);
        s = '0;
        s.loOut = 1'b1;
        addStep(s);
        s = '0;
        s.hiOut = 1'b1;
        addStep(s);
    endtask

    task automatic runImm(input logic sign);
        datapathPkg::instr_t w;
        step_t s;
        w = '0;
        w.immForm.op = datapathPkg::opAdd;
        w.immForm.ra = 4'(randBits(4));
        w.immForm.immValue = {sign, 18'(randBits(18))};
        fetchInstr(w);
        s = '0;
        s.regOut[w.immForm.ra] = 1'b1;
        s.yIn = 1'b1;
        addStep(s);
        s = '0;
        {s.cOut, s.zIn} = 2'b11;  // Bus shows the extended constant
        addStep(s);
        s = '0;
        s.zLowOut = 1'b1;
        addStep(s);
    endtask

    task automatic driveStep(input step_t s);
        regOut = s.regOut;
        regIn = s.regIn;
        {hiOut, hiIn, loOut, loIn} = {s.hiOut, s.hiIn, s.loOut, s.loIn};
        {pcOut, pcIn, incPc, irIn} = {s.pcOut, s.pcIn, s.incPc, s.irIn};
        {marIn, mdrIn, mdrOut, read} = {s.marIn, s.mdrIn, s.mdrOut, s.read};
        {yIn, zIn, zLowOut, zHighOut, cOut} = {s.yIn, s.zIn, s.zLowOut, s.zHighOut, s.cOut};
        memData = s.memData;
    endtask

    task automatic checkBus(input datapathPkg::word_t actual, input datapathPkg::word_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: busValue is %h, expected %h", $time, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Bus value mismatch");
        end
    endtask

    task automatic checkAddress(input datapathPkg::word_t actual,
            input datapathPkg::word_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: memAddress is %h, expected %h", $time, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Memory address mismatch");
        end
    endtask

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: the run went past %0d cycles", cycleLimit);
            $display("=== FAIL ===");
            $fatal(1, "Simulation timed out");
        end
    end

    initial begin
        step_t idle;
        idle = '0;
        driveStep(idle);
        rstN = 1'b0;
        foreach (mRegs[i]) mRegs[i] = '0;
        {mHi, mLo, mPc, mMar, mMdr, mY} = '0;
        mIr = '0;
        mZ = '0;

        addStep(idle);  // Everything clear after reset
        for (int i = 0; i < datapathPkg::numRegs; i++) begin
            loadReg(4'(i), randBits(32));
        end
        for (int i = 0; i < datapathPkg::numRegs; i++) begin
            showReg(4'(i));
        end
        runRegOp(datapathPkg::opAdd);
        runRegOp(datapathPkg::opSub);
        runRegOp(datapathPkg::opAnd);
        runRegOp(datapathPkg::opOr);
        runRegOp(datapathPkg::opShl);
        runRegOp(datapathPkg::opShr);
        runRegOp(datapathPkg::opNeg);
        runRegOp(datapathPkg::opNot);
        runMul();
        runMul();
        runImm(1'b0);
        runImm(1'b1);
        cycleLimit = rows.size() + 2 + 20;

        repeat (2) @(negedge Clock);
        rstN = 1'b1;
        foreach (rows[k]) begin
            @(negedge Clock);
            driveStep(rows[k]);
            #4;  // Just ahead of the rising edge
            if (rows[k].checkBusFlag) checkBus(busValue, rows[k].expBus);
            if (rows[k].checkAddrFlag) checkAddress(memAddress, rows[k].expAddr);
        end
        @(negedge Clock);
        driveStep(idle);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: datapath.f
datapathPkg.sv
busMux.sv
registerFile.sv
specialRegisters.sv
aluStage.sv
datapath.sv
datapathTb.sv

// File: Makefile
# Verilator build and run of the datapath testbench

TOP := datapathTb

all: run

run:
	verilator --binary --timing --top-module $(TOP) -f datapath.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f datapath.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
